// File: design/rename_defs.svh
// Sizing macros; PREGS must be a multiple of 4, at least 8 and at most 512 (10-bit numbers)
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ====================
// Register file sizes
// ====================

// Physical registers over all four banks
`define PREGS 512

// Architectural registers seen by the decoder
`define AREGS 32

// ====================
// Derived widths
// ====================

// The flat physical register number is always 10 bits, the top bits stay zero
`define PREG_W 10
`define AREG_W 5
`define BANK_IDX_W ($clog2(`PREGS / 4))
`define PREG_SPARE_W (`PREG_W - 2 - `BANK_IDX_W)

`endif

// File: design/rename_pkg.sv
// Shared types of the rename stage; the width macros come from rename_defs.svh
`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

	// ====================
	// Physical register number
	// ====================

	// The same 10-bit word is read flat for the map table and compares,
	// and split into bank and index where the bank matters
	typedef union packed {
		// Flat register number, bank times PREGS/4 plus index
		logic [`PREG_W-1:0] raw;
		// Bank-relative view of the same bits
		struct packed {
			// Always zero, kept so the number stays 10 bits wide
			logic [`PREG_SPARE_W-1:0] spare;
			// Which of the four register file banks
			logic [1:0] bank;
			// Position inside the bank, 0 is never handed out
			logic [`BANK_IDX_W-1:0] idx;
		} fields;
	} phys_reg_u;

endpackage

`default_nettype wire

// File: design/free_reg_rotator.sv
// One bank's free pool; assumes in-order retirement, so indices are reused in fixed circular order
`default_nettype none

`include "rename_defs.svh"

module free_reg_rotator #(
	parameter int unsigned bank = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rot,
	output rename_pkg::phys_reg_u head
);

	// Index 0 is reserved, so the pool holds the indices 1 up to the top one
	localparam int depth = `PREGS / 4 - 1;
	localparam int idx_w = `BANK_IDX_W;
	localparam logic [1:0] bank_id = 2'(bank);

	// Circular list of free indices, the front entry is the next one handed out
	logic [idx_w-1:0] mem [depth];

	// ====================
	// Pool rotation
	// ====================

	// The order is the pool's state, so reset rebuilds it as 1, 2, 3 and so on
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= idx_w'(i + 1);
			end
		end else if (rot) begin
			// Shift everything one step toward the front
			for (int i = 0; i < depth - 1; i++) begin
				mem[i] <= mem[i + 1];
			end
			// The index just allocated goes to the back of the line
			mem[depth - 1] <= mem[0];
		end
	end

	// ====================
	// Head presentation
	// ====================

	// The bank field is fixed per instance, only the index comes from the pool
	always_comb begin
		head = '0;
		head.fields.bank = bank_id;
		head.fields.idx = mem[0];
	end

	// ====================
	// Checks
	// ====================

	// Register 0 of a bank must never leave the pool, and the top bits stay clear
	head_never_zero: assert property (@(posedge clk) disable iff (rst)
		head.fields.idx != '0 && head.fields.spare == '0)
	else $error("free_reg_rotator %0d: head index 0 or spare bit set", bank);

endmodule

`default_nettype wire

// File: design/bank_selector.sv
// Round-robin bank choice; there is no stall input, every alloc strobe consumes one register
`default_nettype none

module bank_selector (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  alloc,
	input  rename_pkg::phys_reg_u head0,
	input  rename_pkg::phys_reg_u head1,
	input  rename_pkg::phys_reg_u head2,
	input  rename_pkg::phys_reg_u head3,
	output logic                  rot0,
	output logic                  rot1,
	output logic                  rot2,
	output logic                  rot3,
	output rename_pkg::phys_reg_u new_preg
);

	// Bank that serves the next allocation
	logic [1:0] ptr;

	// ====================
	// Round-robin pointer
	// ====================

	// Wraps from 3 back to 0 on its own through the 2-bit width
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= 2'd0;
		end else if (alloc) begin
			ptr <= ptr + 2'd1;
		end
	end

	// Only the bank that hands out the register advances its pool
	assign rot0 = alloc && (ptr == 2'd0);
	assign rot1 = alloc && (ptr == 2'd1);
	assign rot2 = alloc && (ptr == 2'd2);
	assign rot3 = alloc && (ptr == 2'd3);

	// ====================
	// Head multiplexer
	// ====================

	// Shown every cycle, whether or not an allocation is requested
	always_comb begin
		case (ptr)
			2'd0:    new_preg = head0;
			2'd1:    new_preg = head1;
			2'd2:    new_preg = head2;
			default: new_preg = head3;
		endcase
	end

	// ====================
	// Checks
	// ====================

	rot_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({rot3, rot2, rot1, rot0}))
	else $error("bank_selector: more than one bank rotated");

	// Ties the pointer to the bank number each rotator was built with
	bank_matches_ptr: assert property (@(posedge clk) disable iff (rst)
		new_preg.fields.bank == ptr)
	else $error("bank_selector: head bank %0d does not match pointer %0d",
		new_preg.fields.bank, ptr);

endmodule

`default_nettype wire

// File: design/rename_map.sv
// Architectural-to-physical map; no checkpoints, so a branch flush cannot restore it
`default_nettype none

`include "rename_defs.svh"

module rename_map (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`AREG_W-1:0]    rs1,
	input  logic [`AREG_W-1:0]    rs2,
	input  logic [`AREG_W-1:0]    rd,
	input  logic                  we,
	input  rename_pkg::phys_reg_u wdata,
	output rename_pkg::phys_reg_u src1_preg,
	output rename_pkg::phys_reg_u src2_preg,
	output rename_pkg::phys_reg_u cur_preg
);

	// One entry per architectural register, holding its current physical register
	rename_pkg::phys_reg_u map_q [`AREGS];

	// ====================
	// Write port
	// ====================

	// Reset points every architectural register at physical register 0
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `AREGS; i++) begin
				map_q[i] <= '0;
			end
		end else if (we) begin
			map_q[rd] <= wdata;
		end
	end

	// ====================
	// Read ports
	// ====================

	// All three reads see the table from before this edge's write,
	// so a source equal to its own destination gets the older mapping
	assign src1_preg = map_q[rs1];
	assign src2_preg = map_q[rs2];

	// Prior mapping of the destination, returned as old_pd for later freeing
	assign cur_preg = map_q[rd];

	// ====================
	// Checks
	// ====================

	// Register 0 is only the reset mapping and must never be written back in
	no_zero_write: assert property (@(posedge clk) disable iff (rst)
		we |-> wdata.raw != '0)
	else $error("rename_map: register 0 written to entry %0d", rd);

endmodule

`default_nettype wire

// File: design/rename_unit.sv
// Single-issue rename stage; one request per cycle, no back-pressure, results one cycle later
`default_nettype none

`include "rename_defs.svh"

module rename_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic                  has_rd,
	input  logic [`AREG_W-1:0]    rs1,
	input  logic [`AREG_W-1:0]    rs2,
	input  logic [`AREG_W-1:0]    rd,
	output logic                  out_valid,
	output rename_pkg::phys_reg_u ps1,
	output rename_pkg::phys_reg_u ps2,
	output rename_pkg::phys_reg_u pd,
	output rename_pkg::phys_reg_u old_pd
);

	// A register is consumed only when the instruction writes one
	logic alloc;

	logic rot0;
	logic rot1;
	logic rot2;
	logic rot3;

	rename_pkg::phys_reg_u head0;
	rename_pkg::phys_reg_u head1;
	rename_pkg::phys_reg_u head2;
	rename_pkg::phys_reg_u head3;
	rename_pkg::phys_reg_u new_preg;

	rename_pkg::phys_reg_u src1_preg;
	rename_pkg::phys_reg_u src2_preg;
	rename_pkg::phys_reg_u cur_preg;

	assign alloc = req && has_rd;

	// ====================
	// Free register banks
	// ====================

	free_reg_rotator #(.bank(0)) rot_bank0 (.clk(clk), .rst(rst), .rot(rot0), .head(head0));
	free_reg_rotator #(.bank(1)) rot_bank1 (.clk(clk), .rst(rst), .rot(rot1), .head(head1));
	free_reg_rotator #(.bank(2)) rot_bank2 (.clk(clk), .rst(rst), .rot(rot2), .head(head2));
	free_reg_rotator #(.bank(3)) rot_bank3 (.clk(clk), .rst(rst), .rot(rot3), .head(head3));

	// Spreads consecutive allocations over the four register file banks
	bank_selector sel0 (
		.clk      (clk),
		.rst      (rst),
		.alloc    (alloc),
		.head0    (head0),
		.head1    (head1),
		.head2    (head2),
		.head3    (head3),
		.rot0     (rot0),
		.rot1     (rot1),
		.rot2     (rot2),
		.rot3     (rot3),
		.new_preg (new_preg)
	);

	// ====================
	// Map table
	// ====================

	rename_map map0 (
		.clk       (clk),
		.rst       (rst),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.we        (alloc),
		.wdata     (new_preg),
		.src1_preg (src1_preg),
		.src2_preg (src2_preg),
		.cur_preg  (cur_preg)
	);

	// ====================
	// Output registers
	// ====================

	// One pulse per request, exactly one cycle behind it
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= req;
		end
	end

	// Results are captured on the request edge and hold until the next request
	always_ff @(posedge clk) begin
		if (req) begin
			ps1 <= src1_preg;
			ps2 <= src2_preg;
			// No destination means no allocation, so both report register 0
			pd     <= has_rd ? new_preg : '0;
			old_pd <= has_rd ? cur_preg : '0;
		end
	end

	// ====================
	// Checks
	// ====================

	// An allocating request must come back with a real register in pd
	alloc_gives_reg: assert property (@(posedge clk) disable iff (rst)
		alloc |=> out_valid && pd.raw != '0)
	else $error("rename_unit: allocation returned register 0 or no out_valid");

endmodule

`default_nettype wire

// File: bench/rename_checker.sv
// Reference model of the rename stage; assumes 1-cycle latency and at most one request per cycle
`default_nettype none

`include "rename_defs.svh"

module rename_checker (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic                  has_rd,
	input  logic [`AREG_W-1:0]    rs1,
	input  logic [`AREG_W-1:0]    rs2,
	input  logic [`AREG_W-1:0]    rd,
	input  logic                  out_valid,
	input  rename_pkg::phys_reg_u ps1,
	input  rename_pkg::phys_reg_u ps2,
	input  rename_pkg::phys_reg_u pd,
	input  rename_pkg::phys_reg_u old_pd,
	input  int                    test_num,
	input  logic                  done,
	output logic                  reported,
	output int                    error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int bank_size = `PREGS / 4;

	// Reference copy of the map table, flat register numbers
	logic [`PREG_W-1:0] ref_map [`AREGS];

	int alloc_n = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int wraps = 0;
	int cur_test = 0;
	int test_checks = 0;
	int test_errors = 0;
	logic report_done = 1'b0;

	// What the request seen at the previous edge should return now
	logic exp_valid = 1'b0;
	logic exp_wrap = 1'b0;
	int exp_test = 0;
	logic [`PREG_W-1:0] exp_ps1;
	logic [`PREG_W-1:0] exp_ps2;
	logic [`PREG_W-1:0] exp_pd;
	logic [`PREG_W-1:0] exp_old;

	assign reported = report_done;
	assign error_count = errors;

	// Allocation n goes to bank n mod 4, and the index walks 1 up to the top one, then wraps
	function automatic logic [`PREG_W-1:0] expected_alloc(input int n);
		int bank;
		int idx;
		bank = n % 4;
		idx = 1 + (n / 4) % (bank_size - 1);
		return `PREG_W'(bank * bank_size + idx);
	endfunction

	task automatic compare(input int t, input string name, input logic [`PREG_W-1:0] exp_v,
		input logic [`PREG_W-1:0] act_v);
		checks++;
		test_checks++;
		if (act_v !== exp_v) begin
			errors++;
			test_errors++;
			$display("[ERROR] test %0d at %0t: %s expected 0x%03h, got 0x%03h",
				t, $time, name, exp_v, act_v);
		end
	endtask

	task automatic close_test();
		$display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
		tests++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// ====================
	// Compare and model
	// ====================

	// Sampled on the rising edge, before the DUT's registers take their new values
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `AREGS; i++) begin
				ref_map[i] = '0;
			end
			alloc_n = 0;
			exp_valid = 1'b0;
		end else if (!report_done) begin
			// The pulse must follow a request by exactly one cycle and appear at no other time
			compare(cur_test, "out_valid", `PREG_W'(exp_valid), `PREG_W'(out_valid));
			if (exp_valid && out_valid === 1'b1) begin
				compare(exp_test, "ps1", exp_ps1, ps1.raw);
				compare(exp_test, "ps2", exp_ps2, ps2.raw);
				compare(exp_test, "pd", exp_pd, pd.raw);
				compare(exp_test, "old_pd", exp_old, old_pd.raw);
				// A matching index 1 after the first round means that bank wrapped
				if (exp_wrap && pd.raw === exp_pd) begin
					wraps++;
				end
			end

			exp_valid = req;
			if (req) begin
				if (test_num != cur_test) begin
					if (cur_test != 0) begin
						close_test();
					end
					cur_test = test_num;
				end
				exp_test = test_num;
				// Sources read the table as it was before this request's own write
				exp_ps1 = ref_map[rs1];
				exp_ps2 = ref_map[rs2];
				exp_old = has_rd ? ref_map[rd] : '0;
				exp_pd = has_rd ? expected_alloc(alloc_n) : '0;
				exp_wrap = has_rd && alloc_n >= 4 && ((alloc_n / 4) % (bank_size - 1)) == 0;
				if (has_rd) begin
					ref_map[rd] = exp_pd;
					alloc_n++;
				end
			end

			if (done) begin
				close_test();
				// Every bank has to come back to index 1 at least once during the run
				if (wraps < 4) begin
					errors++;
					$display("Not every bank was seen wrapping its index back to 1 (%0d seen)", wraps);
				end
				$display("tests: %0d, checks: %0d, allocations: %0d, wraps: %0d, errors: %0d",
					tests, checks, alloc_n, wraps, errors);
				report_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_rename_unit.sv
// Testbench for rename_unit; reads bench/rename_input.txt, so it must run from the project root
`default_nettype none

`include "rename_defs.svh"

module tb_rename_unit;
	timeunit 1ns;
	timeprecision 1ps;

	// Cycles allowed for out_valid after a request, and for the checker's totals
	localparam int valid_timeout = 20;
	localparam int report_timeout = 20;

	logic clk;
	logic rst;
	logic req;
	logic has_rd;
	logic [`AREG_W-1:0] rs1;
	logic [`AREG_W-1:0] rs2;
	logic [`AREG_W-1:0] rd;
	logic out_valid;
	rename_pkg::phys_reg_u ps1;
	rename_pkg::phys_reg_u ps2;
	rename_pkg::phys_reg_u pd;
	rename_pkg::phys_reg_u old_pd;

	int test_num;
	logic done;
	logic reported;
	int error_count;
	bit run_ok;

	rename_unit dut0 (
		.clk(clk), .rst(rst), .req(req), .has_rd(has_rd), .rs1(rs1), .rs2(rs2), .rd(rd),
		.out_valid(out_valid), .ps1(ps1), .ps2(ps2), .pd(pd), .old_pd(old_pd)
	);

	rename_checker chk0 (
		.clk(clk), .rst(rst), .req(req), .has_rd(has_rd), .rs1(rs1), .rs2(rs2), .rd(rd),
		.out_valid(out_valid), .ps1(ps1), .ps2(ps2), .pd(pd), .old_pd(old_pd),
		.test_num(test_num), .done(done), .reported(reported), .error_count(error_count)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ====================
	// Driving tasks
	// ====================

	task automatic wait_valid(output bit ok);
		int n;
		n = 0;
		while (out_valid !== 1'b1 && n < valid_timeout) begin
			@(negedge clk);
			n++;
		end
		ok = (out_valid === 1'b1);
		if (!ok) begin
			$display("Timeout: no out_valid within %0d cycles of test %0d's request",
				valid_timeout, test_num);
		end
	endtask

	// Inputs change on the falling edge so the DUT samples them settled
	task automatic drive_request(input int t, input bit r, input bit h, input int a, input int b,
		input int c);
		@(negedge clk);
		test_num = t;
		req = r;
		has_rd = h;
		rs1 = `AREG_W'(a);
		rs2 = `AREG_W'(b);
		rd = `AREG_W'(c);
	endtask

	// Drops req, waits for the last result, then idles out the rest of the gap
	task automatic finish_request(input int idle, input bit had_req, output bit ok);
		ok = 1'b1;
		@(negedge clk);
		req = 1'b0;
		has_rd = 1'b0;
		if (had_req) begin
			wait_valid(ok);
		end
		for (int n = 1; n < idle; n++) begin
			@(negedge clk);
		end
	endtask

	task automatic run_burst(input int t, input int len, output bit ok);
		for (int i = 0; i < len; i++) begin
			drive_request(t, 1'b1, 1'b1, int'($urandom()), int'($urandom()), int'($urandom()));
		end
		finish_request(2, 1'b1, ok);
	endtask

	// Records: '#' comment, 'R' single request, 'B' random burst
	task automatic run_file(output bit ok);
		int fd;
		int code;
		int t;
		int rq;
		int hr;
		int a;
		int b;
		int c;
		int idle;
		bit stop;
		logic [7:0] kind;
		logic [8*160-1:0] skip;
		ok = 1'b1;
		stop = 1'b0;
		fd = $fopen("bench/rename_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/rename_input.txt");
			ok = 1'b0;
			return;
		end
		while (!stop) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				stop = 1'b1;
			end else if (kind == "#") begin
				code = $fgets(skip, fd);
			end else if (kind == "R") begin
				code = $fscanf(fd, "%d %d %d %d %d %d %d", t, rq, hr, a, b, c, idle);
				if (code != 7) begin
					$display("Malformed request record in bench/rename_input.txt");
					ok = 1'b0;
				end else begin
					drive_request(t, rq != 0, hr != 0, a, b, c);
					// Zero idle keeps req high into the next record
					if (idle > 0) begin
						finish_request(idle, rq != 0, ok);
					end
				end
			end else if (kind == "B") begin
				code = $fscanf(fd, "%d %d", t, idle);
				if (code != 2) begin
					$display("Malformed burst record in bench/rename_input.txt");
					ok = 1'b0;
				end else begin
					run_burst(t, idle, ok);
				end
			end else begin
				$display("Unknown record kind in bench/rename_input.txt");
				ok = 1'b0;
			end
			if (!ok) begin
				stop = 1'b1;
			end
		end
		$fclose(fd);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int n;
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		has_rd = 1'b0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		test_num = 0;
		done = 1'b0;
		run_ok = 1'b1;
		void'($urandom(32'h73e691c8));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		run_file(run_ok);
		@(negedge clk);
		done = 1'b1;
		n = 0;
		while (reported !== 1'b1 && n < report_timeout) begin
			@(negedge clk);
			n++;
		end
		if (reported !== 1'b1) begin
			$display("Timeout: the checker did not report its totals");
			run_ok = 1'b0;
		end
		if (run_ok && error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/rename_input.txt
# R test req has_rd rs1 rs2 rd idle   (idle = low cycles after the request, 0 = back-to-back)
# B test burst_length                 (random back-to-back requests, all with a destination)
# Test 1: no destination right after reset, everything maps to register 0
R 1 1 0 0 0 0 2
R 1 1 0 5 31 7 2
R 1 1 0 12 3 9 3
R 1 0 0 0 0 0 2
# Test 2: round-robin allocation over the banks, index 1 first in each
R 2 1 1 0 0 1 2
R 2 1 1 0 0 2 2
R 2 1 1 0 0 3 2
R 2 1 1 0 0 4 2
R 2 1 1 0 0 5 2
R 2 1 1 0 0 8 2
# Test 3: readers see the new mapping, a second rename returns the first as old_pd
R 3 1 0 1 2 0 2
R 3 1 1 3 4 1 2
R 3 1 0 1 5 0 2
R 3 1 1 1 1 1 2
# Test 4: source equal to its own destination reads the previous mapping
R 4 1 1 6 6 6 2
R 4 1 1 6 7 6 2
R 4 1 1 7 6 7 2
# Test 5: back-to-back requests, one per cycle
R 5 1 1 1 2 10 0
R 5 1 1 10 10 11 0
R 5 1 0 11 10 0 0
R 5 1 1 11 11 11 0
R 5 1 1 0 11 12 3
# Test 6: long random burst so every bank wraps its index
B 6 600

// File: verilog.f
+incdir+design
design/rename_pkg.sv
design/free_reg_rotator.sv
design/bank_selector.sv
design/rename_map.sv
design/rename_unit.sv
bench/rename_checker.sv
bench/tb_rename_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the rename stage testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_rename_unit \
	-f verilog.f \
	-o sim_rename

./obj_dir/sim_rename | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi

echo "Simulation finished, log in sim.log"
